// File: Makefile
# Verilator build for the instruction memory access block

VERILATOR  ?= verilator
TOP        := imem_ctrl_tb
FILELIST   := imem_sys.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Everything OK
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation did not pass, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/imem_ctrl_checker.sv
/*
  Handshake checker for the instruction memory block
  Concurrent assertions on the CPU and bus handshakes
*/

`timescale 1ns/100ps
`default_nettype none

module imem_ctrl_checker (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic imem_req_i,
  // Mirrors of the DUT outputs
  input  logic imem_ack_i,
  input  logic bus_req_i,
  input  logic bus_ack_i
);

  ////////////////////////////////////////
  // CPU handshake
  ////////////////////////////////////////

  // Ack only rises while a request was present
  ack_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(imem_ack_i) |-> $past(imem_req_i)
  ) else $error("CPU ack rose without a pending request");

  ////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////

  // Request held until the slave answers
  bus_req_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (bus_req_i && !bus_ack_i) |=> bus_req_i
  ) else $error("Bus request dropped before the slave ack");

  // Bus read and CPU answer never overlap
  no_overlap: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(bus_req_i && imem_ack_i)
  ) else $error("Bus request and CPU ack high together");

  // Quiet outputs right after reset
  reset_quiet: assert property (
    @(posedge clk_i)
    !rst_n_i |=> (!imem_ack_i && !bus_req_i)
  ) else $error("Handshake outputs not low after reset");

endmodule

bind imem_ctrl imem_ctrl_checker i_checker (
  .clk_i      ( clk_i      ),
  .rst_n_i    ( rst_n_i    ),
  .imem_req_i ( imem_req_i ),
  .imem_ack_i ( imem_ack_o ),
  .bus_req_i  ( bus_req_o  ),
  .bus_ack_i  ( bus_ack_i  )
);

`default_nettype wire

// File: dv/imem_ctrl_tb.sv
/*
  Testbench for the instruction memory access block
  Table driven CPU fetches against a bus memory model
  with random slave latency
*/

`timescale 1ns/100ps
`default_nettype none

module imem_ctrl_tb;

  import imem_pkg::*;

  localparam int TBL_LEN     = 16;
  localparam int CYCLE_LIMIT = TBL_LEN * 20;

  // One table row
  typedef struct {
    string           name;
    logic [XLEN-1:0] adr;
    prv_e            prv;
    fetch_result_e   res;
    logic [XLEN-1:0] parcel;
  } fetch_vec_t;

  logic            clk_i;
  logic            rst_n_i;
  logic            imem_req_i;
  logic [XLEN-1:0] imem_adr_i;
  prv_e            imem_prv_i;
  logic            imem_ack_o;
  logic [XLEN-1:0] imem_parcel_o;
  logic            imem_error_o;
  logic            imem_misaligned_o;
  pma_attr_t       pma_cfg [PMA_CNT];
  logic            bus_req_o;
  logic [XLEN-1:0] bus_adr_o;
  logic            bus_user_o;
  logic            bus_ack_i;
  logic [XLEN-1:0] bus_rdata_i;
  logic            bus_err_i;

  fetch_vec_t      tbl [TBL_LEN];
  int              err_cnt;
  int              check_cnt;
  int              cycle_cnt;
  // Bus model bookkeeping
  int              bus_cnt;
  logic [XLEN-1:0] bus_adr_seen;
  logic            bus_user_seen;
  logic [31:0]     rng_state;

  imem_ctrl i_dut (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .imem_req_i        ( imem_req_i        ),
    .imem_adr_i        ( imem_adr_i        ),
    .imem_prv_i        ( imem_prv_i        ),
    .imem_ack_o        ( imem_ack_o        ),
    .imem_parcel_o     ( imem_parcel_o     ),
    .imem_error_o      ( imem_error_o      ),
    .imem_misaligned_o ( imem_misaligned_o ),
    .pma_cfg_i         ( pma_cfg           ),
    .bus_req_o         ( bus_req_o         ),
    .bus_adr_o         ( bus_adr_o         ),
    .bus_user_o        ( bus_user_o        ),
    .bus_ack_i         ( bus_ack_i         ),
    .bus_rdata_i       ( bus_rdata_i       ),
    .bus_err_i         ( bus_err_i         )
  );

  // 20 ns period
  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Erroring window inside region 3
  function automatic logic in_hole(input logic [XLEN-1:0] adr);
    return (adr >= 32'h0800_0000) && (adr < 32'h0800_0100);
  endfunction

  function automatic fetch_vec_t make_entry(input string name, input logic [XLEN-1:0] adr,
                                            input prv_e prv, input fetch_result_e res,
                                            input logic [XLEN-1:0] parcel);
    fetch_vec_t e;
    e.name   = name;
    e.adr    = adr;
    e.prv    = prv;
    e.res    = res;
    e.parcel = parcel;
    return e;
  endfunction

  task automatic set_pma();
    pma_cfg[0] = '{base: 32'h0000_0000, mask: 32'hffff_0000, exec: 1'b1, user: 1'b1};
    // Machine only
    pma_cfg[1] = '{base: 32'h1000_0000, mask: 32'hffff_0000, exec: 1'b1, user: 1'b0};
    pma_cfg[2] = '{base: 32'h2000_0000, mask: 32'hffff_0000, exec: 1'b0, user: 1'b0};
    // Overlaps region 0, lower priority
    pma_cfg[3] = '{base: 32'h0000_0000, mask: 32'hf000_0000, exec: 1'b1, user: 1'b1};
  endtask

  // Good parcels are the address XOR c0de_0000
  task automatic fill_table();
    tbl[0]  = make_entry("r0_m_aligned", 32'h0000_0100, PRV_M, RES_OK, 32'hc0de_0100);
    tbl[1]  = make_entry("r1_m_aligned", 32'h1000_0040, PRV_M, RES_OK, 32'hd0de_0040);
    tbl[2]  = make_entry("r0_s_aligned", 32'h0000_fffc, PRV_S, RES_OK, 32'hc0de_fffc);
    tbl[3]  = make_entry("mis_01", 32'h0000_0101, PRV_M, RES_MISALIGNED, 32'h0);
    tbl[4]  = make_entry("mis_10", 32'h1000_0002, PRV_M, RES_MISALIGNED, 32'h0);
    tbl[5]  = make_entry("mis_11", 32'h2000_0003, PRV_M, RES_MISALIGNED, 32'h0);
    tbl[6]  = make_entry("r2_noexec", 32'h2000_0000, PRV_M, RES_ACCESS, 32'h0);
    tbl[7]  = make_entry("r1_user", 32'h1000_0000, PRV_U, RES_ACCESS, 32'h0);
    tbl[8]  = make_entry("no_region", 32'h3000_0000, PRV_M, RES_ACCESS, 32'h0);
    tbl[9]  = make_entry("r0_user_ok", 32'h0000_0200, PRV_U, RES_OK, 32'hc0de_0200);
    tbl[10] = make_entry("hole_bus_err", 32'h0800_0010, PRV_M, RES_BUS_ERR, 32'h0);
    tbl[11] = make_entry("r3_user_ok", 32'h0123_4568, PRV_U, RES_OK, 32'hc1fd_4568);
    // Back to back, no idle cycle between them
    tbl[12] = make_entry("b2b_0", 32'h0000_1000, PRV_M, RES_OK, 32'hc0de_1000);
    tbl[13] = make_entry("b2b_1", 32'h1000_2000, PRV_M, RES_OK, 32'hd0de_2000);
    tbl[14] = make_entry("b2b_2", 32'h0000_3004, PRV_U, RES_OK, 32'hc0de_3004);
    tbl[15] = make_entry("b2b_3", 32'h0fff_fff0, PRV_U, RES_OK, 32'hcf21_fff0);
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    check_cnt++;
    if (exp !== act)
    begin
      $display("Mismatch %s %s: expected %h, actual %h", name, what, exp, act);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // One CPU fetch, full four-phase cycle
  ////////////////////////////////////////

  task automatic run_fetch(input int idx);
    int   bus_before;
    int   exp_bus;
    logic exp_err;
    logic exp_mis;
    bus_before = bus_cnt;
    exp_err    = (tbl[idx].res == RES_ACCESS) || (tbl[idx].res == RES_BUS_ERR);
    exp_mis    = (tbl[idx].res == RES_MISALIGNED);
    // Only good fetches and bus errors reach the bus
    exp_bus    = ((tbl[idx].res == RES_OK) || (tbl[idx].res == RES_BUS_ERR)) ? 1 : 0;

    imem_adr_i = tbl[idx].adr;
    imem_prv_i = tbl[idx].prv;
    imem_req_i = 1'b1;
    do
    begin
      @(posedge clk_i);
      #2;
    end while (!imem_ack_o);

    check_value(tbl[idx].name, "parcel", tbl[idx].parcel, imem_parcel_o);
    check_value(tbl[idx].name, "error", 32'(exp_err), 32'(imem_error_o));
    check_value(tbl[idx].name, "misaligned", 32'(exp_mis), 32'(imem_misaligned_o));
    check_value(tbl[idx].name, "bus requests", 32'(exp_bus), 32'(bus_cnt - bus_before));
    if (exp_bus == 1)
    begin
      check_value(tbl[idx].name, "bus address", tbl[idx].adr, bus_adr_seen);
      check_value(tbl[idx].name, "bus user", 32'(tbl[idx].prv == PRV_U), 32'(bus_user_seen));
    end

    // Release and wait for the ack to fall
    imem_req_i = 1'b0;
    do
    begin
      @(posedge clk_i);
      #2;
    end while (imem_ack_o);
  endtask

  ////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////

  initial
  begin : bus_model
    logic [1:0] delay;
    bus_ack_i   = 1'b0;
    bus_rdata_i = '0;
    bus_err_i   = 1'b0;
    bus_cnt     = 0;
    rng_state   = 32'h934ba1a3;
    forever
    begin
      @(posedge clk_i);
      #2;
      if (bus_req_o && !bus_ack_i)
      begin
        bus_cnt++;
        bus_adr_seen  = bus_adr_o;
        bus_user_seen = bus_user_o;
        // Slave latency 0 to 3 cycles
        rng_state = xorshift32(rng_state);
        delay     = rng_state[1:0];
        repeat (delay)
        begin
          @(posedge clk_i);
          #2;
        end
        bus_rdata_i = bus_adr_o ^ 32'hc0de_0000;
        bus_err_i   = in_hole(bus_adr_o);
        bus_ack_i   = 1'b1;
        do
        begin
          @(posedge clk_i);
          #2;
        end while (bus_req_o);
        bus_ack_i   = 1'b0;
        bus_err_i   = 1'b0;
        bus_rdata_i = '0;
      end
    end
  end

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial
  begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, fetch sequence did not complete", cycle_cnt);
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin : main_seq
    err_cnt    = 0;
    check_cnt  = 0;
    rst_n_i    = 1'b0;
    imem_req_i = 1'b0;
    imem_adr_i = '0;
    imem_prv_i = PRV_M;
    set_pma();
    fill_table();

    // Two cycles of reset
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #2;

    for (int i = 0; i < TBL_LEN; i++)
      run_fetch(i);

    $display("Fetches: %0d, checks: %0d, errors: %0d", TBL_LEN, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/imem_chk_if.sv
/*
  Registered fetch request
  Links the request stage to the region checkers
  and the fetch controller
*/

`timescale 1ns/100ps
`default_nettype none

interface imem_chk_if;

  import imem_pkg::*;

  // Request held, high until the edge after done
  logic            valid;
  // Registered fetch address
  logic [XLEN-1:0] adr;
  // Privilege of the fetch
  prv_e            prv;
  // Low address bits not zero
  logic            misaligned;
  // One cycle pulse, transaction finished
  logic            done;

  // Request stage side
  modport src (
    output valid, adr, prv, misaligned,
    input  done
  );

  // Region comparators only look at the address
  modport region (
    input adr
  );

  // Fetch controller side
  modport fetch (
    input  valid, adr, prv, misaligned,
    output done
  );

endinterface

`default_nettype wire

// File: hw/imem_ctrl.sv
/*
  Instruction memory access block, no-cache path
  Request stage, PMA region checkers and fetch controller
*/

`timescale 1ns/100ps
`default_nettype none

module imem_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // CPU side
  input  logic                      imem_req_i,
  input  logic [imem_pkg::XLEN-1:0] imem_adr_i,
  input  imem_pkg::prv_e            imem_prv_i,
  output logic                      imem_ack_o,
  output logic [imem_pkg::XLEN-1:0] imem_parcel_o,
  output logic                      imem_error_o,
  output logic                      imem_misaligned_o,

  // PMA configuration
  input  imem_pkg::pma_attr_t       pma_cfg_i [imem_pkg::PMA_CNT],

  // Bus side
  output logic                      bus_req_o,
  output logic [imem_pkg::XLEN-1:0] bus_adr_o,
  output logic                      bus_user_o,
  input  logic                      bus_ack_i,
  input  logic [imem_pkg::XLEN-1:0] bus_rdata_i,
  input  logic                      bus_err_i
);

  import imem_pkg::*;

  // Region results, bit k from checker k
  logic [PMA_CNT-1:0] region_hit;
  logic [PMA_CNT-1:0] region_exec;
  logic [PMA_CNT-1:0] region_user;

  imem_chk_if chk_if ();

  ////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////

  imem_req_stage u_req_stage (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .imem_req_i ( imem_req_i ),
    .imem_adr_i ( imem_adr_i ),
    .imem_prv_i ( imem_prv_i ),
    .chk        ( chk_if.src )
  );

  ////////////////////////////////////////
  // PMA region checkers
  ////////////////////////////////////////

  for (genvar k = 0; k < PMA_CNT; k++)
  begin : g_region
    pma_region_chk u_region_chk (
      .chk    ( chk_if.region  ),
      .attr_i ( pma_cfg_i[k]   ),
      .hit_o  ( region_hit[k]  ),
      .exec_o ( region_exec[k] ),
      .user_o ( region_user[k] )
    );
  end

  ////////////////////////////////////////
  // Fetch control
  ////////////////////////////////////////

  imem_fetch_ctrl u_fetch_ctrl (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .chk               ( chk_if.fetch      ),
    .region_hit_i      ( region_hit        ),
    .region_exec_i     ( region_exec       ),
    .region_user_i     ( region_user       ),
    .imem_req_i        ( imem_req_i        ),
    .imem_ack_o        ( imem_ack_o        ),
    .imem_parcel_o     ( imem_parcel_o     ),
    .imem_error_o      ( imem_error_o      ),
    .imem_misaligned_o ( imem_misaligned_o ),
    .bus_req_o         ( bus_req_o         ),
    .bus_adr_o         ( bus_adr_o         ),
    .bus_user_o        ( bus_user_o        ),
    .bus_ack_i         ( bus_ack_i         ),
    .bus_rdata_i       ( bus_rdata_i       ),
    .bus_err_i         ( bus_err_i         )
  );

endmodule

`default_nettype wire

// File: hw/imem_fetch_ctrl.sv
/*
  Fetch controller
  Resolves the PMA region results, classifies the fetch,
  runs the four-phase bus read and answers the CPU
*/

`timescale 1ns/100ps
`default_nettype none

module imem_fetch_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  // Registered request
  imem_chk_if.fetch                    chk,

  // Region checker results
  input  logic [imem_pkg::PMA_CNT-1:0] region_hit_i,
  input  logic [imem_pkg::PMA_CNT-1:0] region_exec_i,
  input  logic [imem_pkg::PMA_CNT-1:0] region_user_i,

  // CPU side
  input  logic                         imem_req_i,
  output logic                         imem_ack_o,
  output logic [imem_pkg::XLEN-1:0]    imem_parcel_o,
  output logic                         imem_error_o,
  output logic                         imem_misaligned_o,

  // Bus side
  output logic                         bus_req_o,
  output logic [imem_pkg::XLEN-1:0]    bus_adr_o,
  output logic                         bus_user_o,
  input  logic                         bus_ack_i,
  input  logic [imem_pkg::XLEN-1:0]    bus_rdata_i,
  input  logic                         bus_err_i
);

  import imem_pkg::*;

  fetch_state_e    state;
  fetch_result_e   cls;
  fetch_result_e   res_q;
  logic [XLEN-1:0] parcel_q;
  logic            done_q;
  logic            sel_hit;
  logic            sel_exec;
  logic            sel_user;

  ////////////////////////////////////////
  // Region priority and classification
  ////////////////////////////////////////

  // Lowest index hit wins, scan downwards
  always_comb
  begin
    sel_hit  = 1'b0;
    sel_exec = 1'b0;
    sel_user = 1'b0;
    for (int k = PMA_CNT-1; k >= 0; k--)
    begin
      if (region_hit_i[k])
      begin
        sel_hit  = 1'b1;
        sel_exec = region_exec_i[k];
        sel_user = region_user_i[k];
      end
    end
  end

  // Misalignment first, then region checks
  always_comb
  begin
    if (chk.misaligned)
      cls = RES_MISALIGNED;
    else if (!sel_hit || !sel_exec)
      cls = RES_ACCESS;
    else if ((chk.prv == PRV_U) && !sel_user)
      cls = RES_ACCESS;
    else
      cls = RES_OK;
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state      <= FS_IDLE;
      res_q      <= RES_OK;
      bus_req_o  <= 1'b0;
      imem_ack_o <= 1'b0;
      done_q     <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      unique case (state)
        FS_IDLE:
          if (chk.valid)
          begin
            res_q <= cls;
            // Good fetch goes to the bus, faults answer at once
            if (cls == RES_OK)
            begin
              bus_req_o <= 1'b1;
              state     <= FS_BUS_REQ;
            end
            else
            begin
              imem_ack_o <= 1'b1;
              state      <= FS_RESP;
            end
          end
        FS_BUS_REQ:
          if (bus_ack_i)
          begin
            bus_req_o <= 1'b0;
            if (bus_err_i)
              res_q <= RES_BUS_ERR;
            state <= FS_BUS_REL;
          end
        // Slave must drop its ack before the CPU sees ours
        FS_BUS_REL:
          if (!bus_ack_i)
          begin
            imem_ack_o <= 1'b1;
            state      <= FS_RESP;
          end
        FS_RESP:
          if (!imem_req_i)
          begin
            imem_ack_o <= 1'b0;
            done_q     <= 1'b1;
            state      <= FS_WAIT_DROP;
          end
        // Request stage still shows valid this cycle
        FS_WAIT_DROP:
          state <= FS_IDLE;
        default:
          state <= FS_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  // Zero on any fault
  always_ff @(posedge clk_i)
  begin
    if ((state == FS_IDLE) && chk.valid)
      parcel_q <= '0;
    else if ((state == FS_BUS_REQ) && bus_ack_i)
      parcel_q <= bus_err_i ? '0 : bus_rdata_i;
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign chk.done          = done_q;
  assign imem_parcel_o     = parcel_q;
  assign imem_error_o      = (res_q == RES_ACCESS) | (res_q == RES_BUS_ERR);
  assign imem_misaligned_o = (res_q == RES_MISALIGNED);

  // Held stable by the request stage during the bus cycle
  assign bus_adr_o  = chk.adr;
  assign bus_user_o = (chk.prv == PRV_U);

endmodule

`default_nettype wire

// File: hw/imem_pkg.sv
/*
  Instruction memory access package
  Shared widths, PMA region attribute layout and the
  privilege, fetch state and fetch result encodings
*/

`default_nettype none

package imem_pkg;

  ////////////////////////////////////////
  // Widths and counts
  ////////////////////////////////////////

  // Address and instruction word width
  localparam int XLEN    = 32;
  // Number of PMA regions checked per fetch
  localparam int PMA_CNT = 4;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // One PMA region, matched when (adr & mask) == base
  typedef struct packed {
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] mask;
    // Instruction fetch allowed
    logic            exec;
    // User mode may fetch
    logic            user;
  } pma_attr_t;

  // RISC-V privilege encoding
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_M = 2'b11
  } prv_e;

  // Fetch controller FSM
  typedef enum logic [2:0] {
    FS_IDLE,
    FS_BUS_REQ,
    FS_BUS_REL,
    FS_RESP,
    FS_WAIT_DROP
  } fetch_state_e;

  // Outcome of one fetch
  typedef enum logic [1:0] {
    RES_OK,
    RES_MISALIGNED,
    RES_ACCESS,
    RES_BUS_ERR
  } fetch_result_e;

endpackage

`default_nettype wire

// File: hw/imem_req_stage.sv
/*
  Fetch request stage
  Captures one CPU request, holds address and privilege
  until the fetch controller signals done
*/

`timescale 1ns/100ps
`default_nettype none

module imem_req_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // CPU request
  input  logic                      imem_req_i,
  input  logic [imem_pkg::XLEN-1:0] imem_adr_i,
  input  imem_pkg::prv_e            imem_prv_i,

  // Registered request out
  imem_chk_if.src                   chk
);

  ////////////////////////////////////////
  // Capture control
  ////////////////////////////////////////

  logic capture;

  // Capture when idle and a request is present
  // Done only follows a dropped request
  assign capture = ~chk.valid & imem_req_i;

  // Busy flag doubles as the valid flag
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      chk.valid <= 1'b0;
    end
    else
    begin
      // Done wins, new capture from the next cycle
      if (chk.done)
        chk.valid <= 1'b0;
      else if (capture)
        chk.valid <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Request payload
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (capture)
    begin
      chk.adr <= imem_adr_i;
      chk.prv <= imem_prv_i;
    end
  end

  // Word alignment only, no compressed parcels
  assign chk.misaligned = |chk.adr[1:0];

endmodule

`default_nettype wire

// File: hw/pma_region_chk.sv
/*
  PMA region comparator
  Matches the registered fetch address against one
  region and forwards its attributes on a hit
*/

`timescale 1ns/100ps
`default_nettype none

module pma_region_chk (
  // Registered address
  imem_chk_if.region          chk,

  // Region configuration
  input  imem_pkg::pma_attr_t attr_i,

  // Per region results
  output logic                hit_o,
  output logic                exec_o,
  output logic                user_o
);

  ////////////////////////////////////////
  // Address match
  ////////////////////////////////////////

  logic [$bits(attr_i.base)-1:0] masked_adr;

  // Don't care bits removed by the mask
  assign masked_adr = chk.adr & attr_i.mask;

  // Region hit
  assign hit_o = (masked_adr == attr_i.base);

  ////////////////////////////////////////
  // Attributes
  ////////////////////////////////////////

  // Silent when no hit, keeps the priority
  // encoder downstream simple
  assign exec_o = hit_o & attr_i.exec;
  assign user_o = hit_o & attr_i.user;

endmodule

`default_nettype wire

// File: imem_sys.f
hw/imem_pkg.sv
hw/imem_chk_if.sv
hw/imem_req_stage.sv
hw/pma_region_chk.sv
hw/imem_fetch_ctrl.sv
hw/imem_ctrl.sv
dv/imem_ctrl_checker.sv
dv/imem_ctrl_tb.sv
